/* filelist.f */
src/axi_cap_pkg.sv
src/pipeline_reg_slice.sv
src/credit_counter.sv
src/capacity_gate.sv
src/axi_addr_capacity.sv
test/addr_capacity_asserts.sv
test/addr_capacity_checker.sv
test/tb_axi_addr_capacity.sv

/* src/axi_addr_capacity.sv */
// AXI address command capacity gate between two register slices
`timescale 1ns/1ns

module axi_addr_capacity #(
	parameter int ADDR_WIDTH    = axi_cap_pkg::DEF_ADDR_WIDTH,
	parameter int LEN_WIDTH     = axi_cap_pkg::DEF_LEN_WIDTH,
	parameter int USER_WIDTH    = axi_cap_pkg::DEF_USER_WIDTH,
	parameter int COUNTER_WIDTH = axi_cap_pkg::DEF_COUNTER_WIDTH,
	parameter int INIT_CREDIT   = axi_cap_pkg::DEF_INIT_CREDIT
) (
	input  logic                     aclk,
	input  logic                     reset,

	input  logic [COUNTER_WIDTH-1:0] capacity_add,
	input  logic                     capacity_valid,

	input  logic [USER_WIDTH-1:0]    s_user,
	input  logic [ADDR_WIDTH-1:0]    s_addr,
	input  logic [LEN_WIDTH-1:0]     s_len,
	input  logic                     s_valid,
	output logic                     s_ready,

	output logic [USER_WIDTH-1:0]    m_user,
	output logic [ADDR_WIDTH-1:0]    m_addr,
	output logic [LEN_WIDTH-1:0]     m_len,
	output logic                     m_valid,
	input  logic                     m_ready
);

	import axi_cap_pkg::*;

	localparam int CMD_WIDTH = cmd_width(USER_WIDTH, ADDR_WIDTH, LEN_WIDTH);

	typedef logic [CMD_WIDTH-1:0] payload_t;

	payload_t s_data;
	payload_t in_data;
	payload_t m_data;

	logic     in_valid;
	logic     in_ready;
	logic     gate_valid;
	logic     gate_ready;

	// length sits in the low bits
	assign s_data                   = {s_user, s_addr, s_len};
	assign {m_user, m_addr, m_len}  = m_data;

	// -------------------------------------------------------------------------
	// input slice
	// -------------------------------------------------------------------------

	pipeline_reg_slice #(
		.payload_t (payload_t)
	) u_slice_in (
		.clk     (aclk),
		.reset   (reset),
		.s_data  (s_data),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_data  (in_data),
		.m_valid (in_valid),
		.m_ready (in_ready)
	);

	// -------------------------------------------------------------------------
	// credit gate, sees only the length
	// -------------------------------------------------------------------------

	capacity_gate #(
		.LEN_WIDTH     (LEN_WIDTH),
		.COUNTER_WIDTH (COUNTER_WIDTH),
		.INIT_CREDIT   (INIT_CREDIT)
	) u_gate (
		.aclk           (aclk),
		.reset          (reset),
		.in_len         (in_data[LEN_WIDTH-1:0]),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.gate_valid     (gate_valid),
		.gate_ready     (gate_ready),
		.capacity_add   (capacity_add),
		.capacity_valid (capacity_valid)
	);

	// -------------------------------------------------------------------------
	// output slice
	// -------------------------------------------------------------------------

	pipeline_reg_slice #(
		.payload_t (payload_t)
	) u_slice_out (
		.clk     (aclk),
		.reset   (reset),
		.s_data  (in_data),
		.s_valid (gate_valid),
		.s_ready (gate_ready),
		.m_data  (m_data),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

endmodule

/* src/axi_cap_pkg.sv */
// capacity gate package with default widths, initial credit and payload width helper

package axi_cap_pkg;

	// -------------------------------------------------------------------------
	// default field widths
	// -------------------------------------------------------------------------

	// byte address of the burst
	parameter int DEF_ADDR_WIDTH = 32;

	// burst length, coded as beats minus one
	parameter int DEF_LEN_WIDTH = 8;

	// side-band user field
	parameter int DEF_USER_WIDTH = 4;

	// -------------------------------------------------------------------------
	// credit
	// -------------------------------------------------------------------------

	// must hold len+1 of the longest burst plus any returns in flight
	parameter int DEF_COUNTER_WIDTH = 10;

	// beats of downstream buffer space available after reset
	parameter int DEF_INIT_CREDIT = 256;

	// -------------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------------

	// width of the packed command {user, addr, len}
	function automatic int cmd_width(
		input int user_width,
		input int addr_width,
		input int len_width
	);
		int total;
		total = user_width + addr_width + len_width;
		return total;
	endfunction

endpackage

/* src/capacity_gate.sv */
// credit gate that admits a command only when credit covers its whole burst
`timescale 1ns/1ns

module capacity_gate #(
	parameter int LEN_WIDTH     = axi_cap_pkg::DEF_LEN_WIDTH,
	parameter int COUNTER_WIDTH = axi_cap_pkg::DEF_COUNTER_WIDTH,
	parameter int INIT_CREDIT   = axi_cap_pkg::DEF_INIT_CREDIT
) (
	input  logic                     aclk,
	input  logic                     reset,

	// pending command, length only
	input  logic [LEN_WIDTH-1:0]     in_len,
	input  logic                     in_valid,
	output logic                     in_ready,

	output logic                     gate_valid,
	input  logic                     gate_ready,

	input  logic [COUNTER_WIDTH-1:0] capacity_add,
	input  logic                     capacity_valid
);

	logic [COUNTER_WIDTH-1:0] credit;
	logic [COUNTER_WIDTH-1:0] len_ext;
	logic [COUNTER_WIDTH-1:0] burst_beats;
	logic                     credit_ok;
	logic                     admit;

	assign len_ext     = COUNTER_WIDTH'(in_len);
	assign burst_beats = len_ext + COUNTER_WIDTH'(1);

	// credit must cover len+1 beats
	assign credit_ok = credit > len_ext;

	assign gate_valid = in_valid && credit_ok;
	assign in_ready   = gate_ready && credit_ok;

	assign admit = gate_valid && gate_ready;

	credit_counter #(
		.COUNTER_WIDTH (COUNTER_WIDTH),
		.INIT_CREDIT   (INIT_CREDIT)
	) u_counter (
		.aclk       (aclk),
		.reset      (reset),
		.add_amount (capacity_add),
		.add_valid  (capacity_valid),
		.sub_amount (burst_beats),
		.sub_valid  (admit),
		.credit     (credit)
	);

endmodule

/* src/credit_counter.sv */
// saturating credit counter with same-cycle credit return and burst debit
`timescale 1ns/1ns

module credit_counter #(
	parameter int COUNTER_WIDTH = axi_cap_pkg::DEF_COUNTER_WIDTH,
	parameter int INIT_CREDIT   = axi_cap_pkg::DEF_INIT_CREDIT
) (
	input  logic                     aclk,
	input  logic                     reset,

	// credit returned by the downstream buffer
	input  logic [COUNTER_WIDTH-1:0] add_amount,
	input  logic                     add_valid,

	// beats taken by an admitted burst
	input  logic [COUNTER_WIDTH-1:0] sub_amount,
	input  logic                     sub_valid,

	output logic [COUNTER_WIDTH-1:0] credit
);

	// two spare bits: one for carry, one as sign
	localparam int SUM_WIDTH = COUNTER_WIDTH + 2;

	localparam logic [SUM_WIDTH-1:0] CREDIT_MAX = SUM_WIDTH'({COUNTER_WIDTH{1'b1}});

	logic [COUNTER_WIDTH-1:0] credit_q;
	logic [SUM_WIDTH-1:0]     add_ext;
	logic [SUM_WIDTH-1:0]     sub_ext;
	logic [SUM_WIDTH-1:0]     sum;
	logic [COUNTER_WIDTH-1:0] credit_nxt;

	// -------------------------------------------------------------------------
	// next credit
	// -------------------------------------------------------------------------

	assign add_ext = add_valid ? SUM_WIDTH'(add_amount) : '0;
	assign sub_ext = sub_valid ? SUM_WIDTH'(sub_amount) : '0;

	always_comb begin
		sum = SUM_WIDTH'(credit_q) + add_ext - sub_ext;

		if (sum[SUM_WIDTH-1]) begin
			// debit larger than credit, hold at empty
			credit_nxt = '0;
		end else if (sum > CREDIT_MAX) begin
			credit_nxt = CREDIT_MAX[COUNTER_WIDTH-1:0];
		end else begin
			credit_nxt = sum[COUNTER_WIDTH-1:0];
		end
	end

	always_ff @(posedge aclk) begin
		if (reset) begin
			credit_q <= COUNTER_WIDTH'(INIT_CREDIT);
		end else begin
			credit_q <= credit_nxt;
		end
	end

	assign credit = credit_q;

endmodule

/* src/pipeline_reg_slice.sv */
// full-throughput register slice with skid buffer, carrying any payload type
`timescale 1ns/1ns

module pipeline_reg_slice #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     reset,

	input  payload_t s_data,
	input  logic     s_valid,
	output logic     s_ready,

	output payload_t m_data,
	output logic     m_valid,
	input  logic     m_ready
);

	// -------------------------------------------------------------------------
	// storage
	// -------------------------------------------------------------------------

	// main output register
	payload_t out_data;
	logic     out_valid;

	// skid register, catches the item accepted while the output stalls
	payload_t skid_data;
	logic     skid_valid;

	logic     ready_q;

	// next-state controls
	logic     s_fire;
	logic     out_free;
	logic     load_out_from_skid;
	logic     load_out_from_in;
	logic     load_skid;
	logic     out_valid_nxt;
	logic     skid_valid_nxt;

	assign s_fire   = s_valid && ready_q;
	assign out_free = !out_valid || m_ready;

	// -------------------------------------------------------------------------
	// control
	// -------------------------------------------------------------------------

	always_comb begin
		load_out_from_skid = 1'b0;
		load_out_from_in   = 1'b0;
		load_skid          = 1'b0;
		out_valid_nxt      = out_valid;
		skid_valid_nxt     = skid_valid;

		if (out_free) begin
			// skid holds the older item, so it drains first
			if (skid_valid) begin
				load_out_from_skid = 1'b1;
				out_valid_nxt      = 1'b1;
				skid_valid_nxt     = 1'b0;
			end else begin
				load_out_from_in = s_fire;
				out_valid_nxt    = s_fire;
			end
		end else if (s_fire) begin
			load_skid      = 1'b1;
			skid_valid_nxt = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
			ready_q    <= 1'b0;
		end else begin
			out_valid  <= out_valid_nxt;
			skid_valid <= skid_valid_nxt;
			// stays open as long as the skid slot is free
			ready_q    <= !skid_valid_nxt;
		end
	end

	// -------------------------------------------------------------------------
	// payload
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (load_out_from_skid) begin
			out_data <= skid_data;
		end else if (load_out_from_in) begin
			out_data <= s_data;
		end
		if (load_skid) begin
			skid_data <= s_data;
		end
	end

	assign s_ready = ready_q;
	assign m_data  = out_data;
	assign m_valid = out_valid;

endmodule

/* test/addr_capacity_asserts.sv */
// concurrent checks on m-port hold, reset values and the input slice ready
`timescale 1ns/1ns

module addr_capacity_asserts #(
	parameter int ADDR_WIDTH = axi_cap_pkg::DEF_ADDR_WIDTH,
	parameter int LEN_WIDTH  = axi_cap_pkg::DEF_LEN_WIDTH,
	parameter int USER_WIDTH = axi_cap_pkg::DEF_USER_WIDTH
) (
	input logic                  aclk,
	input logic                  reset,
	input logic                  s_ready,
	input logic                  in_valid,
	input logic [USER_WIDTH-1:0] m_user,
	input logic [ADDR_WIDTH-1:0] m_addr,
	input logic [LEN_WIDTH-1:0]  m_len,
	input logic                  m_valid,
	input logic                  m_ready
);

	int fail_count = 0;

	// stalled command must hold until taken
	a_m_hold: assert property (@(posedge aclk) disable iff (reset)
		m_valid && !m_ready |=> m_valid && $stable({m_user, m_addr, m_len}))
		else begin
			fail_count++;
			$error("m-port command changed or dropped while m_ready was low");
		end

	a_reset_m_valid: assert property (@(posedge aclk) reset |=> !m_valid)
		else begin
			fail_count++;
			$error("m_valid high during reset");
		end

	a_reset_s_ready: assert property (@(posedge aclk) reset |=> !s_ready)
		else begin
			fail_count++;
			$error("s_ready high during reset");
		end

	a_ready_after_reset: assert property (@(posedge aclk) $fell(reset) |=> s_ready)
		else begin
			fail_count++;
			$error("s_ready not raised after reset");
		end

	// empty input slice cannot fill its skid register in one cycle
	a_empty_keeps_ready: assert property (@(posedge aclk) disable iff (reset)
		!in_valid && s_ready |=> s_ready)
		else begin
			fail_count++;
			$error("s_ready dropped while the input slice was empty");
		end

endmodule

/* test/addr_capacity_checker.sv */
// scoreboard for the capacity gate with queue model, credit model and closing report
`timescale 1ns/1ns

module addr_capacity_checker #(
	parameter int ADDR_WIDTH    = axi_cap_pkg::DEF_ADDR_WIDTH,
	parameter int LEN_WIDTH     = axi_cap_pkg::DEF_LEN_WIDTH,
	parameter int USER_WIDTH    = axi_cap_pkg::DEF_USER_WIDTH,
	parameter int COUNTER_WIDTH = axi_cap_pkg::DEF_COUNTER_WIDTH,
	parameter int INIT_CREDIT   = axi_cap_pkg::DEF_INIT_CREDIT
) (
	input  logic                     aclk,
	input  logic                     reset,
	input  logic [USER_WIDTH-1:0]    s_user,
	input  logic [ADDR_WIDTH-1:0]    s_addr,
	input  logic [LEN_WIDTH-1:0]     s_len,
	input  logic                     s_valid,
	input  logic                     s_ready,
	input  logic [USER_WIDTH-1:0]    m_user,
	input  logic [ADDR_WIDTH-1:0]    m_addr,
	input  logic [LEN_WIDTH-1:0]     m_len,
	input  logic                     m_valid,
	input  logic                     m_ready,
	input  logic [COUNTER_WIDTH-1:0] capacity_add,
	input  logic                     capacity_valid,
	input  int                       timeout_errors,
	input  int                       assert_errors,
	input  logic                     report,
	output int                       total_errors
);

	import axi_cap_pkg::*;

	localparam int CMD_WIDTH   = cmd_width(USER_WIDTH, ADDR_WIDTH, LEN_WIDTH);
	localparam int ADDR_LSB    = LEN_WIDTH;
	localparam int USER_LSB    = LEN_WIDTH + ADDR_WIDTH;
	localparam int STALL_LIMIT = 20;

	logic [CMD_WIDTH-1:0] expected_q[$];
	logic [CMD_WIDTH-1:0] m_cmd;
	logic [CMD_WIDTH-1:0] held_cmd;
	logic                 held;
	logic                 reset_prev;
	bit                   return_seen;
	int                   issued_beats;
	int                   returned_beats;
	int                   stall_cycles;
	int                   data_errors;
	int                   credit_errors;
	int                   live_errors;
	int                   hold_errors;
	int                   reset_errors;
	int                   lost_errors;

	assign m_cmd = {m_user, m_addr, m_len};
	assign total_errors = data_errors + credit_errors + live_errors + hold_errors
		+ reset_errors + lost_errors + timeout_errors + assert_errors;

	initial begin
		held = 1'b0;
		reset_prev = 1'b0;
		data_errors = 0;
		credit_errors = 0;
		live_errors = 0;
		hold_errors = 0;
		reset_errors = 0;
		lost_errors = 0;
	end

	function automatic int compare_cmd(input string tag, input logic [CMD_WIDTH-1:0] exp_cmd,
		input logic [CMD_WIDTH-1:0] got_cmd);
		int bad;
		bad = 0;
		if (got_cmd[USER_LSB +: USER_WIDTH] !== exp_cmd[USER_LSB +: USER_WIDTH]) begin
			$display("MISMATCH m_user%s: expected 0x%h, got 0x%h", tag,
				exp_cmd[USER_LSB +: USER_WIDTH], got_cmd[USER_LSB +: USER_WIDTH]);
			bad++;
		end
		if (got_cmd[ADDR_LSB +: ADDR_WIDTH] !== exp_cmd[ADDR_LSB +: ADDR_WIDTH]) begin
			$display("MISMATCH m_addr%s: expected 0x%h, got 0x%h", tag,
				exp_cmd[ADDR_LSB +: ADDR_WIDTH], got_cmd[ADDR_LSB +: ADDR_WIDTH]);
			bad++;
		end
		if (got_cmd[LEN_WIDTH-1:0] !== exp_cmd[LEN_WIDTH-1:0]) begin
			$display("MISMATCH m_len%s: expected 0x%h, got 0x%h", tag,
				exp_cmd[LEN_WIDTH-1:0], got_cmd[LEN_WIDTH-1:0]);
			bad++;
		end
		return bad;
	endfunction

	// ------------------------------------------------------------------------
	// per-cycle model
	// ------------------------------------------------------------------------

	always @(posedge aclk) begin
		if (reset) begin
			if (reset_prev && m_valid !== 1'b0) begin
				$display("ERROR: m_valid is high during reset at %0t", $time);
				reset_errors++;
			end
			expected_q.delete();
			issued_beats = 0;
			returned_beats = 0;
			stall_cycles = 0;
			held = 1'b0;
			return_seen = 1'b0;
		end else begin
			if (reset_prev && m_valid !== 1'b0) begin
				$display("ERROR: m_valid is high in the first cycle after reset");
				reset_errors++;
			end
			// stalled command must not change
			if (held) begin
				if (m_valid !== 1'b1) begin
					$display("ERROR: m_valid dropped while stalled at %0t", $time);
					hold_errors++;
				end else begin
					hold_errors += compare_cmd(" (held)", held_cmd, m_cmd);
				end
			end
			held = m_valid && !m_ready;
			held_cmd = m_cmd;

			// liveness against the credit seen at the m port
			if (m_valid && m_ready) begin
				stall_cycles = 0;
			end else if (expected_q.size() > 0 && INIT_CREDIT + returned_beats - issued_beats
					> int'(expected_q[0][LEN_WIDTH-1:0])) begin
				if (m_ready) begin
					stall_cycles++;
				end
				if (stall_cycles > STALL_LIMIT) begin
					$display("ERROR: command with enough credit stuck for %0d cycles at %0t",
						STALL_LIMIT, $time);
					live_errors++;
					stall_cycles = 0;
				end
			end else begin
				stall_cycles = 0;
			end

			// the whole initial credit goes out before the first return
			if (capacity_valid) begin
				if (!return_seen && issued_beats != INIT_CREDIT) begin
					$display("ERROR: %0d beats issued before the first credit return, not %0d",
						issued_beats, INIT_CREDIT);
					credit_errors++;
				end
				return_seen = 1'b1;
				returned_beats += int'(capacity_add);
			end

			if (m_valid && m_ready) begin
				if (expected_q.size() == 0) begin
					$display("ERROR: m-port transfer with no pending command at %0t", $time);
					data_errors++;
				end else begin
					data_errors += compare_cmd("", expected_q.pop_front(), m_cmd);
				end
				issued_beats += m_len + 1;
				if (issued_beats > INIT_CREDIT + returned_beats) begin
					$display("ERROR: credit overdrawn, %0d beats issued against %0d granted",
						issued_beats, INIT_CREDIT + returned_beats);
					credit_errors++;
				end
			end

			if (s_valid && s_ready) begin
				expected_q.push_back({s_user, s_addr, s_len});
			end
		end
		reset_prev = reset;
	end

	// ------------------------------------------------------------------------
	// closing report
	// ------------------------------------------------------------------------

	always @(posedge report) begin
		if (expected_q.size() != 0) begin
			$display("ERROR: %0d accepted commands never left the m port", expected_q.size());
			lost_errors++;
		end
		$display(
			"errors: data=%0d credit=%0d live=%0d hold=%0d reset=%0d lost=%0d timeout=%0d assert=%0d",
			data_errors, credit_errors, live_errors, hold_errors, reset_errors, lost_errors,
			timeout_errors, assert_errors);
	end

endmodule

/* test/tb_axi_addr_capacity.sv */
// testbench for the AXI address capacity gate with random commands, stalls and credit returns
`timescale 1ns/1ns

module tb_axi_addr_capacity;

	import axi_cap_pkg::*;

	localparam int NUM_CMDS        = 2000;
	localparam int HANDSHAKE_LIMIT = 5000;
	localparam int DRAIN_LIMIT     = 20000;
	localparam logic [31:0] SEED   = 32'h34563cba;

	logic                         aclk;
	logic                         reset;
	logic [DEF_COUNTER_WIDTH-1:0] capacity_add;
	logic                         capacity_valid;
	logic [DEF_USER_WIDTH-1:0]    s_user;
	logic [DEF_ADDR_WIDTH-1:0]    s_addr;
	logic [DEF_LEN_WIDTH-1:0]     s_len;
	logic                         s_valid;
	logic                         s_ready;
	logic [DEF_USER_WIDTH-1:0]    m_user;
	logic [DEF_ADDR_WIDTH-1:0]    m_addr;
	logic [DEF_LEN_WIDTH-1:0]     m_len;
	logic                         m_valid;
	logic                         m_ready;
	logic                         report;
	int                           timeout_errors;
	int                           assert_errors;
	int                           total_errors;
	int                           cmds_sent;
	int                           m_count;
	int                           beats_issued;
	int                           beats_unreturned;
	int                           fill_beats;

	axi_addr_capacity #(
		.ADDR_WIDTH    (DEF_ADDR_WIDTH),
		.LEN_WIDTH     (DEF_LEN_WIDTH),
		.USER_WIDTH    (DEF_USER_WIDTH),
		.COUNTER_WIDTH (DEF_COUNTER_WIDTH),
		.INIT_CREDIT   (DEF_INIT_CREDIT)
	) dut0 (
		.aclk (aclk), .reset (reset),
		.capacity_add (capacity_add), .capacity_valid (capacity_valid),
		.s_user (s_user), .s_addr (s_addr), .s_len (s_len),
		.s_valid (s_valid), .s_ready (s_ready),
		.m_user (m_user), .m_addr (m_addr), .m_len (m_len),
		.m_valid (m_valid), .m_ready (m_ready)
	);

	bind axi_addr_capacity addr_capacity_asserts #(
		.ADDR_WIDTH (ADDR_WIDTH), .LEN_WIDTH (LEN_WIDTH), .USER_WIDTH (USER_WIDTH)
	) u_asserts (
		.aclk (aclk), .reset (reset), .s_ready (s_ready), .in_valid (in_valid),
		.m_user (m_user), .m_addr (m_addr), .m_len (m_len),
		.m_valid (m_valid), .m_ready (m_ready)
	);

	assign assert_errors = dut0.u_asserts.fail_count;

	addr_capacity_checker chk0 (
		.aclk (aclk), .reset (reset),
		.s_user (s_user), .s_addr (s_addr), .s_len (s_len),
		.s_valid (s_valid), .s_ready (s_ready),
		.m_user (m_user), .m_addr (m_addr), .m_len (m_len),
		.m_valid (m_valid), .m_ready (m_ready),
		.capacity_add (capacity_add), .capacity_valid (capacity_valid),
		.timeout_errors (timeout_errors), .assert_errors (assert_errors),
		.report (report), .total_errors (total_errors)
	);

	always #50 aclk = ~aclk;

	// mostly short bursts, some near the full credit; the first ones fill it exactly
	task automatic pick_len(output int len);
		if ($urandom % 8 == 0) begin
			len = 200 + $urandom % 56;
		end else begin
			len = $urandom % 64;
		end
		if (fill_beats < DEF_INIT_CREDIT) begin
			if (len + 1 > DEF_INIT_CREDIT - fill_beats) begin
				len = DEF_INIT_CREDIT - fill_beats - 1;
			end
			fill_beats += len + 1;
		end
	endtask

	task automatic send_cmd(input int len, output bit ok);
		int waited;
		bit accepted;
		repeat ($urandom % 4) begin
			@(posedge aclk);
			#5;
		end
		s_user = DEF_USER_WIDTH'($urandom);
		s_addr = DEF_ADDR_WIDTH'($urandom);
		s_len = DEF_LEN_WIDTH'(len);
		s_valid = 1'b1;
		waited = 0;
		accepted = 1'b0;
		while (!accepted && waited < HANDSHAKE_LIMIT) begin
			@(negedge aclk);
			accepted = s_ready;
			@(posedge aclk);
			#5;
			waited++;
		end
		s_valid = 1'b0;
		ok = accepted;
	endtask

	// m-port consumer with stalls, returns credit once the initial credit is used
	task automatic run_sink();
		int stall_left;
		int amount;
		stall_left = 0;
		while (!report) begin
			@(negedge aclk);
			if (m_valid && m_ready) begin
				m_count++;
				beats_issued += m_len + 1;
				beats_unreturned += m_len + 1;
			end
			@(posedge aclk);
			#5;
			if (stall_left > 0) begin
				stall_left--;
				m_ready = 1'b0;
			end else if ($urandom % 100 == 0) begin
				stall_left = 20 + $urandom % 60;
				m_ready = 1'b0;
			end else begin
				m_ready = ($urandom % 4 != 0);
			end
			capacity_valid = 1'b0;
			if (beats_issued >= DEF_INIT_CREDIT && beats_unreturned > 0 && $urandom % 3 == 0) begin
				amount = 1 + $urandom % beats_unreturned;
				capacity_add = DEF_COUNTER_WIDTH'(amount);
				capacity_valid = 1'b1;
				beats_unreturned -= amount;
			end
		end
	endtask

	initial begin
		bit ok;
		int len;
		int waited;
		aclk = 1'b0;
		reset = 1'b1;
		capacity_add = '0;
		capacity_valid = 1'b0;
		s_user = '0;
		s_addr = '0;
		s_len = '0;
		s_valid = 1'b0;
		m_ready = 1'b0;
		report = 1'b0;
		timeout_errors = 0;
		cmds_sent = 0;
		m_count = 0;
		beats_issued = 0;
		beats_unreturned = 0;
		fill_beats = 0;
		void'($urandom(SEED));

		repeat (3) @(posedge aclk);
		#5;
		reset = 1'b0;

		fork
			run_sink();
		join_none

		ok = 1'b1;
		while (ok && cmds_sent < NUM_CMDS) begin
			pick_len(len);
			send_cmd(len, ok);
			if (ok) begin
				cmds_sent++;
			end else begin
				$display("ERROR: s_ready never accepted command %0d", cmds_sent);
				timeout_errors++;
			end
		end

		waited = 0;
		while (m_count < cmds_sent && waited < DRAIN_LIMIT) begin
			@(posedge aclk);
			waited++;
		end
		if (m_count < cmds_sent) begin
			$display("ERROR: only %0d of %0d commands left the m port", m_count, cmds_sent);
			timeout_errors++;
		end

		repeat (5) @(posedge aclk);
		report = 1'b1;
		#1;
		if (total_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
